//--- common/xdma_ctrl_pkg.sv
// Shared widths, message structs, window indices and window address helpers for the adapter
package xdma_ctrl_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned AddrWidth   = 48;
  localparam int unsigned WordWidth   = 64;
  localparam int unsigned ChipIdWidth = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [WordWidth-1:0] word_t;
  typedef logic [7:0]           dma_id_t;
  typedef logic [6:0]           frame_len_t;

  // Region layout
  localparam addr_t ClusterAddrSpace = 48'h0000_0010_0000;
  localparam addr_t MainMemBase      = 48'h0000_8000_0000;
  localparam addr_t MainMemEnd       = 48'h0001_0000_0000;
  localparam addr_t WindowSize       = 48'h0000_0000_1000;
  localparam addr_t WordBytes        = 48'd8;

  // --------------------------------------------------
  // Messages
  // --------------------------------------------------
  // First frame of a configuration message
  typedef struct packed {
    dma_id_t    dma_id;
    // 0 read, 1 write
    logic       dma_type;
    // Header included
    frame_len_t frame_length;
    addr_t      peer_addr;
  } cfg_header_t;

  // Grant and finish notes share one layout
  typedef struct packed {
    dma_id_t    dma_id;
    addr_t      from_addr;
    logic [7:0] reserved;
  } ctrl_note_t;

  // Single-beat write
  typedef struct packed {
    addr_t addr;
    word_t data;
  } ctrl_write_t;

  // Windows counted back from the region end
  typedef enum logic [1:0] {
    WinFinish = 2'd0,
    WinGrant  = 2'd1,
    WinCfg    = 2'd2
  } window_e;

  // --------------------------------------------------
  // Address helpers
  // --------------------------------------------------
  function automatic addr_t region_end(addr_t addr);
    // Main memory keeps the chip id, low bits end at 4 GiB
    if (addr[AddrWidth-ChipIdWidth-1:0] >= MainMemBase[AddrWidth-ChipIdWidth-1:0]) begin
      return {addr[AddrWidth-1:AddrWidth-ChipIdWidth],
              MainMemEnd[AddrWidth-ChipIdWidth-1:0]};
    end
    // Cluster region, aligned down then one region up
    return (addr & ~(ClusterAddrSpace - addr_t'(1))) + ClusterAddrSpace;
  endfunction

  function automatic addr_t window_base(addr_t addr, window_e win);
    return region_end(addr) - (addr_t'(win) + addr_t'(1)) * WindowSize;
  endfunction

endpackage

//--- sender/xdma_cfg_framer.sv
// Splits configuration messages into header and body beats and addresses each beat for the peer
module xdma_cfg_framer
  import xdma_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Frames from the outside
  input  word_t       cfg_i,
  input  logic        cfg_valid_i,
  output logic        cfg_ready_o,
  // Addressed beats towards the arbiter
  output ctrl_write_t cfg_write_o,
  output logic        cfg_write_valid_o,
  input  logic        cfg_write_ready_i,
  output logic        cfg_last_o
);

  typedef enum logic {
    FrameIdle,
    FrameBody
  } state_e;

  state_e      state_q, state_d;
  cfg_header_t header;
  addr_t       beat_addr;
  addr_t       base_q;
  frame_len_t  len_q;
  // Body frames already sent
  frame_len_t  cnt_q;
  frame_len_t  body_idx;
  logic        beat_accept;

  // Beats pass straight through
  assign cfg_ready_o       = cfg_write_ready_i;
  assign cfg_write_valid_o = cfg_valid_i;
  assign beat_accept       = cfg_valid_i && cfg_ready_o;
  assign header            = cfg_header_t'(cfg_i);
  assign body_idx          = cnt_q + frame_len_t'(1);

  // --------------------------------------------------
  // Header tracking
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    beat_addr  = window_base(header.peer_addr, WinCfg);
    cfg_last_o = 1'b0;
    case (state_q)
      FrameIdle: begin
        // Single-frame message ends on its header
        cfg_last_o = header.frame_length <= frame_len_t'(1);
        if (beat_accept && !cfg_last_o) begin
          state_d = FrameBody;
        end
      end
      FrameBody: begin
        beat_addr  = base_q + WordBytes * addr_t'(body_idx);
        cfg_last_o = body_idx == len_q - frame_len_t'(1);
        if (beat_accept && cfg_last_o) begin
          state_d = FrameIdle;
        end
      end
      default: state_d = FrameIdle;
    endcase
  end

  assign cfg_write_o.addr = beat_addr;
  assign cfg_write_o.data = cfg_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FrameIdle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (beat_accept) begin
        cnt_q <= (state_q == FrameIdle) ? frame_len_t'(0) : body_idx;
      end
    end
  end

  // Window base and length latched from the header
  always_ff @(posedge clk_i) begin
    if (beat_accept && state_q == FrameIdle) begin
      base_q <= beat_addr;
      len_q  <= header.frame_length;
    end
  end

  // Every accepted header announces at least itself
  a_header_len_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_accept && state_q == FrameIdle |-> header.frame_length != '0);

endmodule

//--- sender/xdma_ctrl_write_arbiter.sv
// Addresses grant and finish notes and merges them with config beats onto one outbound write port
module xdma_ctrl_write_arbiter
  import xdma_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Config beats from the framer
  input  ctrl_write_t cfg_write_i,
  input  logic        cfg_write_valid_i,
  output logic        cfg_write_ready_o,
  input  logic        cfg_last_i,
  // Notes
  input  ctrl_note_t  grant_note_i,
  input  logic        grant_valid_i,
  output logic        grant_ready_o,
  input  ctrl_note_t  finish_note_i,
  input  logic        finish_valid_i,
  output logic        finish_ready_o,
  // Outbound write port
  output ctrl_write_t out_write_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  typedef enum logic [1:0] {
    SrcCfg,
    SrcGrant,
    SrcFinish
  } src_e;

  src_e        sel, held_sel_q;
  ctrl_write_t grant_write, finish_write;
  // Inside a multi-frame config message
  logic        lock_q;
  // Stalled beat keeps its source
  logic        hold_q;

  always_comb begin
    grant_write.addr  = window_base(grant_note_i.from_addr, WinGrant);
    grant_write.data  = word_t'(grant_note_i);
    finish_write.addr = window_base(finish_note_i.from_addr, WinFinish);
    finish_write.data = word_t'(finish_note_i);

    // Fixed priority, finish first
    if (lock_q) sel = SrcCfg;
    else if (hold_q) sel = held_sel_q;
    else if (finish_valid_i) sel = SrcFinish;
    else if (grant_valid_i) sel = SrcGrant;
    else sel = SrcCfg;

    case (sel)
      SrcFinish: begin
        out_write_o = finish_write;
        out_valid_o = finish_valid_i;
      end
      SrcGrant: begin
        out_write_o = grant_write;
        out_valid_o = grant_valid_i;
      end
      default: begin
        out_write_o = cfg_write_i;
        out_valid_o = cfg_write_valid_i;
      end
    endcase
  end

  // Unselected sources see ready low
  assign cfg_write_ready_o = out_ready_i && (sel == SrcCfg);
  assign grant_ready_o     = out_ready_i && (sel == SrcGrant);
  assign finish_ready_o    = out_ready_i && (sel == SrcFinish);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      hold_q     <= 1'b0;
      held_sel_q <= SrcCfg;
    end else begin
      if (cfg_write_valid_i && cfg_write_ready_o) begin
        lock_q <= !cfg_last_i;
      end
      hold_q     <= out_valid_o && !out_ready_i;
      held_sel_q <= sel;
    end
  end

  // Payload on the port does not change under back-pressure
  a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> $stable(out_write_o));

endmodule

//--- receiver/xdma_ctrl_write_demux.sv
// Decodes inbound writes against the local cfg, grant and finish windows and routes them
module xdma_ctrl_write_demux
  import xdma_ctrl_pkg::*;
(
  // Inbound writes
  input  ctrl_write_t in_write_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  addr_t       cluster_base_addr_i,
  // Configuration words
  output word_t       cfg_o,
  output logic        cfg_valid_o,
  input  logic        cfg_ready_i,
  // Finish notes
  output ctrl_note_t  finish_o,
  output logic        finish_valid_o,
  input  logic        finish_ready_i,
  // Grants into the FIFO
  output ctrl_note_t  grant_push_o,
  output logic        grant_push_valid_o,
  input  logic        grant_push_ready_i,
  output logic        decode_error_o
);

  addr_t cfg_base, grant_base, finish_base;
  logic  cfg_hit, grant_hit, finish_hit;

  // --------------------------------------------------
  // Local windows
  // --------------------------------------------------
  assign cfg_base    = window_base(cluster_base_addr_i, WinCfg);
  assign grant_base  = window_base(cluster_base_addr_i, WinGrant);
  assign finish_base = window_base(cluster_base_addr_i, WinFinish);

  assign cfg_hit    = in_write_i.addr >= cfg_base && in_write_i.addr < cfg_base + WindowSize;
  assign grant_hit  = in_write_i.addr >= grant_base && in_write_i.addr < grant_base + WindowSize;
  assign finish_hit = in_write_i.addr >= finish_base &&
                      in_write_i.addr < finish_base + WindowSize;

  // Data fans out unchanged
  assign cfg_o        = in_write_i.data;
  assign finish_o     = ctrl_note_t'(in_write_i.data);
  assign grant_push_o = ctrl_note_t'(in_write_i.data);

  assign cfg_valid_o        = in_valid_i && cfg_hit;
  assign grant_push_valid_o = in_valid_i && grant_hit;
  assign finish_valid_o     = in_valid_i && finish_hit;

  always_comb begin
    // Unmatched writes are swallowed
    if (cfg_hit) in_ready_o = cfg_ready_i;
    else if (grant_hit) in_ready_o = grant_push_ready_i;
    else if (finish_hit) in_ready_o = finish_ready_i;
    else in_ready_o = 1'b1;
  end

  // Pulse in the transfer cycle of a dropped write
  assign decode_error_o = in_valid_i && !(cfg_hit || grant_hit || finish_hit);

  // Windows never overlap
  always_comb begin
    a_one_target : assert ($onehot0({cfg_valid_o, grant_push_valid_o, finish_valid_o}));
  end

endmodule

//--- receiver/xdma_grant_fifo.sv
// Queues received grants and keeps the grant level high until the local write finishes
module xdma_grant_fifo
  import xdma_ctrl_pkg::*;
#(
  parameter int Depth = 3
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  ctrl_note_t push_note_i,
  input  logic       push_valid_i,
  output logic       push_ready_o,
  // One-cycle pulse per finished local write
  input  logic       write_finish_i,
  output logic       grant_o,
  output dma_id_t    grant_id_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  dma_id_t mem_q [Depth];
  ptr_t    rd_ptr_q, wr_ptr_q;
  cnt_t    count_q;
  logic    push, pop;

  assign push_ready_o = count_q != cnt_t'(Depth);
  assign grant_o      = count_q != '0;
  assign grant_id_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  // Finish pulse on an empty queue is ignored
  assign pop  = write_finish_i && grant_o;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? ptr_t'(0) : ptr + ptr_t'(1);
  endfunction

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop) count_q <= count_q + cnt_t'(1);
      else if (pop && !push) count_q <= count_q - cnt_t'(1);
    end
  end

  // Only the id is kept
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_note_i.dma_id;
  end

  // Pointers meet only when the queue is empty or full
  a_count_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_t'(Depth) &&
    ((rd_ptr_q == wr_ptr_q) == (count_q == '0 || count_q == cnt_t'(Depth))));

endmodule

//--- design/xdma_ctrl_adapter_top.sv
// Control-message side of the inter-cluster DMA adapter, sender and receiver paths
module xdma_ctrl_adapter_top
  import xdma_ctrl_pkg::*;
#(
  parameter int GrantFifoDepth = 3
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  addr_t       cluster_base_addr_i,
  // Sender inputs
  input  word_t       cfg_i,
  input  logic        cfg_valid_i,
  output logic        cfg_ready_o,
  input  ctrl_note_t  grant_note_i,
  input  logic        grant_note_valid_i,
  output logic        grant_note_ready_o,
  input  ctrl_note_t  finish_note_i,
  input  logic        finish_note_valid_i,
  output logic        finish_note_ready_o,
  // Outbound and inbound write ports
  output ctrl_write_t out_write_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  input  ctrl_write_t in_write_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  // Receiver outputs
  output word_t       from_remote_cfg_o,
  output logic        from_remote_cfg_valid_o,
  input  logic        from_remote_cfg_ready_i,
  output ctrl_note_t  from_remote_finish_o,
  output logic        from_remote_finish_valid_o,
  input  logic        from_remote_finish_ready_i,
  output logic        grant_o,
  output dma_id_t     grant_id_o,
  input  logic        write_finish_i,
  output logic        decode_error_o
);

  // --------------------------------------------------
  // Sender
  // --------------------------------------------------
  ctrl_write_t cfg_write;
  logic        cfg_write_valid, cfg_write_ready, cfg_last;

  xdma_cfg_framer i_cfg_framer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_i             (cfg_i),
    .cfg_valid_i       (cfg_valid_i),
    .cfg_ready_o       (cfg_ready_o),
    .cfg_write_o       (cfg_write),
    .cfg_write_valid_o (cfg_write_valid),
    .cfg_write_ready_i (cfg_write_ready),
    .cfg_last_o        (cfg_last)
  );

  xdma_ctrl_write_arbiter i_write_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_write_i       (cfg_write),
    .cfg_write_valid_i (cfg_write_valid),
    .cfg_write_ready_o (cfg_write_ready),
    .cfg_last_i        (cfg_last),
    .grant_note_i      (grant_note_i),
    .grant_valid_i     (grant_note_valid_i),
    .grant_ready_o     (grant_note_ready_o),
    .finish_note_i     (finish_note_i),
    .finish_valid_i    (finish_note_valid_i),
    .finish_ready_o    (finish_note_ready_o),
    .out_write_o       (out_write_o),
    .out_valid_o       (out_valid_o),
    .out_ready_i       (out_ready_i)
  );

  // --------------------------------------------------
  // Receiver
  // --------------------------------------------------
  ctrl_note_t grant_push_note;
  logic       grant_push_valid, grant_push_ready;

  xdma_ctrl_write_demux i_write_demux (
    .in_write_i          (in_write_i),
    .in_valid_i          (in_valid_i),
    .in_ready_o          (in_ready_o),
    .cluster_base_addr_i (cluster_base_addr_i),
    .cfg_o               (from_remote_cfg_o),
    .cfg_valid_o         (from_remote_cfg_valid_o),
    .cfg_ready_i         (from_remote_cfg_ready_i),
    .finish_o            (from_remote_finish_o),
    .finish_valid_o      (from_remote_finish_valid_o),
    .finish_ready_i      (from_remote_finish_ready_i),
    .grant_push_o        (grant_push_note),
    .grant_push_valid_o  (grant_push_valid),
    .grant_push_ready_i  (grant_push_ready),
    .decode_error_o      (decode_error_o)
  );

  xdma_grant_fifo #(
    .Depth (GrantFifoDepth)
  ) i_grant_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_note_i    (grant_push_note),
    .push_valid_i   (grant_push_valid),
    .push_ready_o   (grant_push_ready),
    .write_finish_i (write_finish_i),
    .grant_o        (grant_o),
    .grant_id_o     (grant_id_o)
  );

endmodule

//--- verification/tb_xdma_ctrl_adapter.sv
// Testbench that drives random traffic through both adapter paths and checks it against a model
module tb_xdma_ctrl_adapter
  import xdma_ctrl_pkg::*;
;

  localparam int GrantDepth = 3;
  localparam int MaxCycles  = 20000;
  // Inbound targets numbered like the windows
  localparam int KindFinish = 0;
  localparam int KindGrant  = 1;
  localparam int KindCfg    = 2;
  localparam int KindNone   = 3;

  logic        clk_i, rst_ni;
  addr_t       cluster_base_addr_i;
  word_t       cfg_i;
  logic        cfg_valid_i, cfg_ready_o;
  ctrl_note_t  grant_note_i, finish_note_i;
  logic        grant_note_valid_i, grant_note_ready_o;
  logic        finish_note_valid_i, finish_note_ready_o;
  ctrl_write_t out_write_o, in_write_i;
  logic        out_valid_o, out_ready_i, in_valid_i, in_ready_o;
  word_t       from_remote_cfg_o;
  logic        from_remote_cfg_valid_o, from_remote_cfg_ready_i;
  ctrl_note_t  from_remote_finish_o;
  logic        from_remote_finish_valid_o, from_remote_finish_ready_i;
  logic        grant_o, write_finish_i, decode_error_o;
  dma_id_t     grant_id_o;

  // Model state
  ctrl_write_t exp_q [$];
  dma_id_t     grant_q [$];
  int          cycles;
  int          in_kind;
  bit          pulse_en;
  addr_t       local_base;

  xdma_ctrl_adapter_top #(
    .GrantFifoDepth (GrantDepth)
  ) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Model helpers
  // --------------------------------------------------
  // Window address counted back from the region end
  function automatic addr_t window_addr(addr_t a, int idx);
    addr_t top;
    if (a[39:0] >= 40'h00_8000_0000) top = {a[47:40], 40'h01_0000_0000};
    else top = {a[47:20], 20'h0_0000} + 48'h10_0000;
    return top - addr_t'(idx + 1) * 48'h1000;
  endfunction

  // Bit 31 picks main memory or cluster space
  function automatic addr_t random_peer();
    addr_t a;
    a = addr_t'({$urandom, $urandom});
    a[39:32] = 8'h00;
    a[31] = ($urandom % 2) == 1;
    return a;
  endfunction

  function automatic ctrl_note_t random_note();
    ctrl_note_t n;
    n.dma_id    = dma_id_t'($urandom);
    n.from_addr = random_peer();
    n.reserved  = 8'h00;
    return n;
  endfunction

  task automatic compare_value(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic expect_note(ctrl_note_t note, bit is_finish);
    ctrl_write_t w;
    w.addr = window_addr(note.from_addr, is_finish ? KindFinish : KindGrant);
    w.data = word_t'(note);
    exp_q.push_back(w);
  endtask

  task automatic check_idle_outputs();
    compare_value("out_valid_o", out_valid_o, 1'b0);
    compare_value("from_remote_cfg_valid_o", from_remote_cfg_valid_o, 1'b0);
    compare_value("from_remote_finish_valid_o", from_remote_finish_valid_o, 1'b0);
    compare_value("grant_o", grant_o, 1'b0);
    compare_value("decode_error_o", decode_error_o, 1'b0);
  endtask

  // --------------------------------------------------
  // Drivers
  // --------------------------------------------------
  task automatic send_note(bit is_finish, ctrl_note_t note);
    @(negedge clk_i);
    if (is_finish) begin
      finish_note_i       = note;
      finish_note_valid_i = 1'b1;
    end else begin
      grant_note_i       = note;
      grant_note_valid_i = 1'b1;
    end
    do begin
      @(posedge clk_i);
    end while (is_finish ? !finish_note_ready_o : !grant_note_ready_o);
    @(negedge clk_i);
    if (is_finish) finish_note_valid_i = 1'b0;
    else grant_note_valid_i = 1'b0;
  endtask

  // Header plus body beats with an optional grant note raised mid-message
  task automatic send_message(int len, bit with_grant);
    cfg_header_t hdr;
    word_t       words [6];
    ctrl_write_t w;
    ctrl_note_t  note;
    addr_t       peer, base;
    bit          hdr_done;
    peer             = random_peer();
    hdr.dma_id       = dma_id_t'($urandom);
    hdr.dma_type     = ($urandom % 2) == 1;
    hdr.frame_length = frame_len_t'(len);
    hdr.peer_addr    = peer;
    words[0]         = word_t'(hdr);
    base             = window_addr(peer, KindCfg);
    hdr_done         = 1'b0;
    for (int k = 0; k < len; k++) begin
      if (k > 0) words[k] = {$urandom, $urandom};
      w.addr = base + addr_t'(8 * k);
      w.data = words[k];
      exp_q.push_back(w);
    end
    // Note must wait behind the whole message
    note = random_note();
    if (with_grant) expect_note(note, 1'b0);
    fork
      begin
        for (int k = 0; k < len; k++) begin
          @(negedge clk_i);
          cfg_i       = words[k];
          cfg_valid_i = 1'b1;
          do begin
            @(posedge clk_i);
          end while (!cfg_ready_o);
          hdr_done = 1'b1;
        end
        @(negedge clk_i);
        cfg_valid_i = 1'b0;
      end
      begin
        if (with_grant) begin
          while (!hdr_done) @(negedge clk_i);
          send_note(1'b0, note);
        end
      end
    join
  endtask

  task automatic send_inbound(int kind, addr_t addr, word_t data);
    @(negedge clk_i);
    in_kind         = kind;
    in_write_i.addr = addr;
    in_write_i.data = data;
    in_valid_i      = 1'b1;
    do begin
      @(posedge clk_i);
      if (kind == KindCfg) compare_value("in_ready_o", in_ready_o, from_remote_cfg_ready_i);
      if (kind == KindFinish) compare_value("in_ready_o", in_ready_o, from_remote_finish_ready_i);
      if (kind == KindNone) compare_value("in_ready_o", in_ready_o, 1'b1);
    end while (!in_ready_o);
    compare_value("from_remote_cfg_valid_o", from_remote_cfg_valid_o, kind == KindCfg);
    compare_value("from_remote_finish_valid_o", from_remote_finish_valid_o, kind == KindFinish);
    if (kind == KindCfg) compare_value("from_remote_cfg_o", from_remote_cfg_o, data);
    if (kind == KindFinish) compare_value("from_remote_finish_o", from_remote_finish_o, data);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // Random back-pressure and finish pulses
  always @(negedge clk_i) begin
    out_ready_i                = ($urandom % 4) != 0;
    from_remote_cfg_ready_i    = ($urandom % 4) != 0;
    from_remote_finish_ready_i = ($urandom % 4) != 0;
    write_finish_i             = pulse_en && (($urandom % 4) == 0);
  end

  // --------------------------------------------------
  // Monitor and reference model
  // --------------------------------------------------
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
    if (rst_ni) begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Outbound write to %h arrived with no write expected", out_write_o.addr);
          $display("Simulation failed");
          $fatal(1, "unexpected outbound write");
        end
        compare_value("out_write_o.addr", out_write_o.addr, exp_q[0].addr);
        compare_value("out_write_o.data", out_write_o.data, exp_q[0].data);
        void'(exp_q.pop_front());
      end
      // Back-pressure reaches every sender source
      if (!out_ready_i) begin
        compare_value("cfg_ready_o", cfg_ready_o, 1'b0);
        compare_value("grant_note_ready_o", grant_note_ready_o, 1'b0);
        compare_value("finish_note_ready_o", finish_note_ready_o, 1'b0);
      end
      // Error pulse only in the cycle of a dropped write
      compare_value("decode_error_o", decode_error_o, in_valid_i && in_kind == KindNone);
      compare_value("grant_o", grant_o, grant_q.size() != 0);
      if (grant_q.size() != 0) compare_value("grant_id_o", grant_id_o, grant_q[0]);
      if (in_valid_i && in_kind == KindGrant)
        compare_value("in_ready_o", in_ready_o, grant_q.size() < GrantDepth);
      // Pop before push and ignore a pulse on an empty queue
      if (write_finish_i && grant_q.size() != 0) void'(grant_q.pop_front());
      if (in_valid_i && in_ready_o && in_kind == KindGrant)
        grant_q.push_back(in_write_i.data[63:56]);
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    ctrl_note_t fin, gnt;
    int         kind;
    addr_t      addr;
    void'($urandom(32'h8d32_448b));
    cycles = 0;
    in_kind = KindNone;
    pulse_en = 1'b0;
    rst_ni = 1'b0;
    cluster_base_addr_i = '0;
    cfg_i = '0;
    cfg_valid_i = 1'b0;
    grant_note_i = '0;
    grant_note_valid_i = 1'b0;
    finish_note_i = '0;
    finish_note_valid_i = 1'b0;
    out_ready_i = 1'b1;
    in_write_i = '0;
    in_valid_i = 1'b0;
    from_remote_cfg_ready_i = 1'b1;
    from_remote_finish_ready_i = 1'b1;
    write_finish_i = 1'b0;
    repeat (16) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle_outputs();

    // Configuration messages with a note behind some of them
    for (int i = 0; i < 400; i++) send_message(1 + int'($urandom % 6), ($urandom % 3) == 0);

    // Both notes at once with finish going first
    for (int i = 0; i < 300; i++) begin
      fin = random_note();
      gnt = random_note();
      expect_note(fin, 1'b1);
      expect_note(gnt, 1'b0);
      fork
        send_note(1'b1, fin);
        send_note(1'b0, gnt);
      join
    end

    // Inbound decoding against a cluster-space base
    local_base = addr_t'({$urandom, $urandom});
    local_base[39:31] = '0;
    @(negedge clk_i);
    cluster_base_addr_i = local_base;
    pulse_en = 1'b1;
    for (int i = 0; i < 1500; i++) begin
      kind = int'($urandom % 4);
      if (kind == KindNone)
        addr = window_addr(local_base, KindCfg) - addr_t'(8 * (1 + $urandom % 512));
      else
        addr = window_addr(local_base, kind) + addr_t'(8 * ($urandom % 512));
      send_inbound(kind, addr, {$urandom, $urandom});
    end

    // Fill the grant queue so that one more stalls until a pulse frees a slot
    pulse_en = 1'b0;
    while (grant_q.size() < GrantDepth)
      send_inbound(KindGrant, window_addr(local_base, KindGrant), {$urandom, $urandom});
    fork
      send_inbound(KindGrant, window_addr(local_base, KindGrant), {$urandom, $urandom});
      begin
        repeat (8) @(posedge clk_i);
        pulse_en = 1'b1;
      end
    join
    while (grant_q.size() != 0) @(posedge clk_i);
    // Pulses on an empty queue
    repeat (20) @(posedge clk_i);
    compare_value("pending outbound writes", exp_q.size(), 0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- all.f
common/xdma_ctrl_pkg.sv
sender/xdma_cfg_framer.sv
sender/xdma_ctrl_write_arbiter.sv
receiver/xdma_ctrl_write_demux.sv
receiver/xdma_grant_fifo.sv
design/xdma_ctrl_adapter_top.sv
verification/tb_xdma_ctrl_adapter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the control adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_xdma_ctrl_adapter --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
